// ==== hdl/mips_pkg.sv ====
package mips_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_HALT  = 6'h3f;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_SLT = 3'd4;

    localparam logic [1:0] FWD_REG = 2'd0;
    localparam logic [1:0] FWD_MEM = 2'd1; // From EX/MEM
    localparam logic [1:0] FWD_WB  = 2'd2; // From MEM/WB

    typedef union packed {
        struct packed {
            logic [5:0]        opcode;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [REG_AW-1:0] rd;
            logic [4:0]        shamt;
            logic [5:0]        funct;
        } rtype;
        struct packed {
            logic [5:0]        opcode;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [15:0]       imm;
        } itype;
    } instr_t;

endpackage

// ==== hdl/pipe_ifs.sv ====
`timescale 1ns/1ps

interface id_ex_if;
    import mips_pkg::*;

    logic              valid;
    logic              reg_write;
    logic              mem_read;
    logic              mem_write;
    logic              branch;
    logic              alu_src;
    logic              is_halt;
    logic [2:0]        alu_op;
    logic [XLEN-1:0]   rs_val;
    logic [XLEN-1:0]   rt_val;
    logic [XLEN-1:0]   imm;        // Sign extended
    logic [REG_AW-1:0] rs;
    logic [REG_AW-1:0] rt;
    logic [REG_AW-1:0] dest;
    logic [XLEN-1:0]   pc_plus4;

    modport decode (output valid, reg_write, mem_read, mem_write, branch, alu_src, is_halt,
                    alu_op, rs_val, rt_val, imm, rs, rt, dest, pc_plus4);
    modport execute (input valid, reg_write, mem_read, mem_write, branch, alu_src, is_halt,
                     alu_op, rs_val, rt_val, imm, rs, rt, dest, pc_plus4);
endinterface

interface ex_mem_if;
    import mips_pkg::*;

    logic              valid;
    logic              reg_write;
    logic              mem_read;
    logic              mem_write;
    logic              branch;
    logic              is_halt;
    logic              zero;
    logic [XLEN-1:0]   alu_result;
    logic [XLEN-1:0]   store_data;
    logic [REG_AW-1:0] dest;
    logic [XLEN-1:0]   branch_target;

    modport execute (output valid, reg_write, mem_read, mem_write, branch, is_halt, zero,
                     alu_result, store_data, dest, branch_target);
    modport memory (input valid, reg_write, mem_read, mem_write, branch, is_halt, zero,
                    alu_result, store_data, dest, branch_target);
endinterface

interface wb_bypass_if;
    import mips_pkg::*;

    logic [REG_AW-1:0] mem_dest;
    logic              mem_reg_write; // Already qualified by valid
    logic [XLEN-1:0]   mem_result;
    logic [REG_AW-1:0] wb_dest;
    logic              wb_reg_write;
    logic [XLEN-1:0]   wb_data;

    modport source (output mem_dest, mem_reg_write, mem_result, wb_dest, wb_reg_write, wb_data);
    modport forward (input mem_dest, mem_reg_write, mem_result, wb_dest, wb_reg_write, wb_data);
    modport regwrite (input wb_dest, wb_reg_write, wb_data);
endinterface

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
    parameter int IM_DEPTH = 64
) (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_run,
    input  logic                        i_im_write,
    input  logic [$clog2(IM_DEPTH)-1:0] i_im_addr,
    input  logic [mips_pkg::XLEN-1:0]   i_im_data,
    input  logic                        i_stall,
    input  logic                        i_halt_seen,
    input  logic                        i_halted,
    input  logic                        i_branch_taken,
    input  logic [mips_pkg::XLEN-1:0]   i_branch_target,
    output logic                        o_if_valid,
    output logic [mips_pkg::XLEN-1:0]   o_if_instr,
    output logic [mips_pkg::XLEN-1:0]   o_if_pc_plus4
);
    import mips_pkg::*;

    localparam int IM_AW = $clog2(IM_DEPTH);

    logic [XLEN-1:0] imem [IM_DEPTH];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;
    logic            fetch_en;

    assign pc_plus4 = pc + XLEN'(4);
    assign fetch_en = i_run && !i_stall && !i_halt_seen && !i_halted;

    always_ff @(posedge i_clock) begin
        if (i_im_write) begin
            imem[i_im_addr] <= i_im_data; // Whole-word loader
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            pc <= '0;
        end else if (i_branch_taken) begin
            pc <= i_branch_target;
        end else if (fetch_en) begin
            pc <= pc_plus4;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset || i_branch_taken) begin
            o_if_valid <= 1'b0;
        end else if (!i_stall) begin
            o_if_valid <= fetch_en; // Gated fetch leaves a bubble
        end
    end

    always_ff @(posedge i_clock) begin
        if (fetch_en) begin
            o_if_instr    <= imem[pc[IM_AW+1:2]];
            o_if_pc_plus4 <= pc_plus4;
        end
    end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_halted,
    input  logic                        i_branch_taken,
    input  logic                        i_if_valid,
    input  mips_pkg::instr_t            i_if_instr,
    input  logic [mips_pkg::XLEN-1:0]   i_if_pc_plus4,
    input  logic [mips_pkg::REG_AW-1:0] i_rb_addr,
    output logic                        o_stall,
    output logic                        o_halt_seen,
    output logic [mips_pkg::XLEN-1:0]   o_rb_data,
    id_ex_if.decode                     id_ex,
    wb_bypass_if.regwrite               wb
);
    import mips_pkg::*;

    logic [XLEN-1:0]   regs [1 << REG_AW];
    logic [REG_AW-1:0] rs;
    logic [REG_AW-1:0] rt;
    logic [REG_AW-1:0] dest;
    logic [XLEN-1:0]   imm;
    logic [2:0]        alu_op;
    logic              reg_write;
    logic              mem_read;
    logic              mem_write;
    logic              branch;
    logic              alu_src;
    logic              is_halt;
    logic              uses_rt;
    logic              halt_flag;

    // Same-cycle WB write goes straight through
    function automatic logic [XLEN-1:0] rf_read(input logic [REG_AW-1:0] addr);
        if (wb.wb_reg_write && wb.wb_dest == addr) begin
            return wb.wb_data;
        end
        return regs[addr];
    endfunction

    assign rs  = i_if_instr.itype.rs;
    assign rt  = i_if_instr.itype.rt;
    assign imm = {{(XLEN-16){i_if_instr.itype.imm[15]}}, i_if_instr.itype.imm};

    always_comb begin
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        alu_src   = 1'b0;
        is_halt   = 1'b0;
        uses_rt   = 1'b0;
        alu_op    = ALU_ADD;
        dest      = rt;
        case (i_if_instr.rtype.opcode)
            OP_RTYPE: begin
                reg_write = 1'b1;
                uses_rt   = 1'b1;
                dest      = i_if_instr.rtype.rd;
                case (i_if_instr.rtype.funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: reg_write = 1'b0; // Unknown funct is a nop
                endcase
            end
            OP_ADDI: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            OP_LW: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                alu_src   = 1'b1;
            end
            OP_SW: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                uses_rt   = 1'b1;
            end
            OP_BEQ: begin
                branch  = 1'b1;
                uses_rt = 1'b1;
                alu_op  = ALU_SUB;
            end
            OP_HALT: is_halt = 1'b1;
            default: ;
        endcase
    end

    // Load-use hazard against a lw in ID/EX
    // A lw to r0 has reg_write low and never stalls
    assign o_stall = i_if_valid && id_ex.valid && id_ex.mem_read && id_ex.reg_write &&
                     ((!is_halt && id_ex.dest == rs) || (uses_rt && id_ex.dest == rt));

    assign o_halt_seen = halt_flag || (i_if_valid && is_halt);

    always_ff @(posedge i_clock) begin
        if (i_reset || i_branch_taken) begin
            halt_flag <= 1'b0;
        end else if (i_if_valid && is_halt) begin
            halt_flag <= 1'b1;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < (1 << REG_AW); i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wb_reg_write) begin
            regs[wb.wb_dest] <= wb.wb_data;
        end
    end

    always_ff @(posedge i_clock) begin
        o_rb_data <= rf_read(i_rb_addr); // Debug read
    end

    always_ff @(posedge i_clock) begin
        if (i_reset || i_branch_taken) begin
            id_ex.valid <= 1'b0;
        end else if (!i_halted) begin
            id_ex.valid <= i_if_valid && !o_stall;
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_halted) begin
            id_ex.reg_write <= reg_write && (dest != '0);
            id_ex.mem_read  <= mem_read;
            id_ex.mem_write <= mem_write;
            id_ex.branch    <= branch;
            id_ex.alu_src   <= alu_src;
            id_ex.is_halt   <= is_halt;
            id_ex.alu_op    <= alu_op;
            id_ex.rs_val    <= rf_read(rs);
            id_ex.rt_val    <= rf_read(rt);
            id_ex.imm       <= imm;
            id_ex.rs        <= rs;
            id_ex.rt        <= rt;
            id_ex.dest      <= dest;
            id_ex.pc_plus4  <= i_if_pc_plus4;
        end
    end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic         i_clock,
    input  logic         i_reset,
    input  logic         i_halted,
    input  logic         i_branch_taken,
    id_ex_if.execute     id_ex,
    ex_mem_if.execute    ex_mem,
    wb_bypass_if.forward bp
);
    import mips_pkg::*;

    logic [1:0]      fwd_a;
    logic [1:0]      fwd_b;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;

    // EX/MEM wins over MEM/WB
    function automatic logic [1:0] fwd_sel(input logic [REG_AW-1:0] src);
        if (bp.mem_reg_write && bp.mem_dest == src) begin
            return FWD_MEM;
        end
        if (bp.wb_reg_write && bp.wb_dest == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    function automatic logic [XLEN-1:0] fwd_val(input logic [1:0] sel,
                                                 input logic [XLEN-1:0] reg_val);
        case (sel)
            FWD_MEM: return bp.mem_result;
            FWD_WB:  return bp.wb_data;
            default: return reg_val;
        endcase
    endfunction

    assign fwd_a = fwd_sel(id_ex.rs);
    assign fwd_b = fwd_sel(id_ex.rt);
    assign op_a  = fwd_val(fwd_a, id_ex.rs_val);
    assign op_b  = fwd_val(fwd_b, id_ex.rt_val);
    assign alu_b = id_ex.alu_src ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB: alu_result = op_a - alu_b;
            ALU_AND: alu_result = op_a & alu_b;
            ALU_OR:  alu_result = op_a | alu_b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            default: alu_result = op_a + alu_b;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset || i_branch_taken) begin
            ex_mem.valid <= 1'b0;
        end else if (!i_halted) begin
            ex_mem.valid <= id_ex.valid;
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_halted) begin
            ex_mem.reg_write     <= id_ex.reg_write;
            ex_mem.mem_read      <= id_ex.mem_read;
            ex_mem.mem_write     <= id_ex.mem_write;
            ex_mem.branch        <= id_ex.branch;
            ex_mem.is_halt       <= id_ex.is_halt;
            ex_mem.zero          <= (alu_result == '0);
            ex_mem.alu_result    <= alu_result;
            ex_mem.store_data    <= op_b;   // Forwarded rt
            ex_mem.dest          <= id_ex.dest;
            ex_mem.branch_target <= id_ex.pc_plus4 + {id_ex.imm[XLEN-3:0], 2'b00};
        end
    end

endmodule

// ==== hdl/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage #(
    parameter int DM_DEPTH = 32
) (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic [$clog2(DM_DEPTH)-1:0] i_dm_addr,
    output logic                        o_branch_taken,
    output logic [mips_pkg::XLEN-1:0]   o_branch_target,
    output logic                        o_halted,
    output logic [mips_pkg::XLEN-1:0]   o_dm_data,
    ex_mem_if.memory                    ex_mem,
    wb_bypass_if.source                 bp
);
    import mips_pkg::*;

    localparam int DM_AW = $clog2(DM_DEPTH);

    logic [XLEN-1:0]  dmem [DM_DEPTH];
    logic [DM_AW-1:0] dm_idx;
    logic [XLEN-1:0]  load_data;
    logic             wb_halt;

    assign dm_idx    = ex_mem.alu_result[DM_AW+1:2]; // Word address
    assign load_data = dmem[dm_idx];

    assign o_branch_taken  = ex_mem.valid && ex_mem.branch && ex_mem.zero;
    assign o_branch_target = ex_mem.branch_target;

    assign bp.mem_dest      = ex_mem.dest;
    assign bp.mem_reg_write = ex_mem.valid && ex_mem.reg_write;
    assign bp.mem_result    = ex_mem.alu_result;

    always_ff @(posedge i_clock) begin
        if (ex_mem.valid && ex_mem.mem_write && !o_halted) begin
            dmem[dm_idx] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge i_clock) begin
        o_dm_data <= dmem[i_dm_addr]; // Debug read
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            bp.wb_reg_write <= 1'b0;
            wb_halt         <= 1'b0;
        end else if (!o_halted) begin
            bp.wb_reg_write <= ex_mem.valid && ex_mem.reg_write;
            wb_halt         <= ex_mem.valid && ex_mem.is_halt;
        end
    end

    // Writeback mux ahead of MEM/WB
    always_ff @(posedge i_clock) begin
        if (!o_halted) begin
            bp.wb_dest <= ex_mem.dest;
            bp.wb_data <= ex_mem.mem_read ? load_data : ex_mem.alu_result;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_halted <= 1'b0;
        end else if (wb_halt) begin
            o_halted <= 1'b1; // Sticky until reset
        end
    end

endmodule

// ==== hdl/mips_pipeline.sv ====
`timescale 1ns/1ps

module mips_pipeline #(
    parameter int IM_DEPTH = 64,
    parameter int DM_DEPTH = 32
) (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_run,
    input  logic                        i_im_write,
    input  logic [$clog2(IM_DEPTH)-1:0] i_im_addr,
    input  logic [mips_pkg::XLEN-1:0]   i_im_data,
    input  logic [mips_pkg::REG_AW-1:0] i_rb_addr,
    input  logic [$clog2(DM_DEPTH)-1:0] i_dm_addr,
    output logic                        o_hlt,
    output logic [mips_pkg::XLEN-1:0]   o_rb_data,
    output logic [mips_pkg::XLEN-1:0]   o_dm_data
);
    import mips_pkg::*;

    logic            if_valid;
    logic [XLEN-1:0] if_instr;
    logic [XLEN-1:0] if_pc_plus4;
    logic            stall;
    logic            halt_seen;
    logic            branch_taken;  // Also the flush
    logic [XLEN-1:0] branch_target;

    id_ex_if     id_ex ();
    ex_mem_if    ex_mem ();
    wb_bypass_if bypass ();

    fetch_stage #(.IM_DEPTH(IM_DEPTH)) u_fetch (
        .i_clock(i_clock), .i_reset(i_reset), .i_run(i_run),
        .i_im_write(i_im_write), .i_im_addr(i_im_addr), .i_im_data(i_im_data),
        .i_stall(stall), .i_halt_seen(halt_seen), .i_halted(o_hlt),
        .i_branch_taken(branch_taken), .i_branch_target(branch_target),
        .o_if_valid(if_valid), .o_if_instr(if_instr), .o_if_pc_plus4(if_pc_plus4)
    );

    decode_stage u_decode (
        .i_clock(i_clock), .i_reset(i_reset), .i_halted(o_hlt),
        .i_branch_taken(branch_taken),
        .i_if_valid(if_valid), .i_if_instr(if_instr), .i_if_pc_plus4(if_pc_plus4),
        .i_rb_addr(i_rb_addr),
        .o_stall(stall), .o_halt_seen(halt_seen), .o_rb_data(o_rb_data),
        .id_ex(id_ex.decode), .wb(bypass.regwrite)
    );

    execute_stage u_execute (
        .i_clock(i_clock), .i_reset(i_reset), .i_halted(o_hlt),
        .i_branch_taken(branch_taken),
        .id_ex(id_ex.execute), .ex_mem(ex_mem.execute), .bp(bypass.forward)
    );

    memory_stage #(.DM_DEPTH(DM_DEPTH)) u_memory (
        .i_clock(i_clock), .i_reset(i_reset), .i_dm_addr(i_dm_addr),
        .o_branch_taken(branch_taken), .o_branch_target(branch_target),
        .o_halted(o_hlt), .o_dm_data(o_dm_data),
        .ex_mem(ex_mem.memory), .bp(bypass.source)
    );

endmodule

// ==== dv/mips_pipeline_sva.sv ====
`timescale 1ns/1ps

module mips_pipeline_sva (
    input logic i_clock,
    input logic i_reset,
    input logic o_hlt,
    input logic branch_taken,
    input logic if_valid,
    input logic stall
);

    // Halt is sticky until reset
    hlt_sticky: assert property (@(posedge i_clock) (o_hlt && !i_reset) |=> o_hlt)
        else $error("o_hlt fell without reset");

    hlt_low_after_reset: assert property (@(posedge i_clock) i_reset |=> !o_hlt)
        else $error("o_hlt high after reset");

    // Flush leaves a bubble in IF/ID
    flush_if_id: assert property (@(posedge i_clock) disable iff (i_reset)
        branch_taken |=> !if_valid)
        else $error("IF/ID valid after a taken branch");

    stall_one_cycle: assert property (@(posedge i_clock) disable iff (i_reset)
        stall |=> !stall)
        else $error("load-use stall lasted two cycles");

endmodule

bind mips_pipeline mips_pipeline_sva i_sva (
    .i_clock(i_clock),
    .i_reset(i_reset),
    .o_hlt(o_hlt),
    .branch_taken(branch_taken),
    .if_valid(if_valid),
    .stall(stall)
);

// ==== dv/mips_pipeline_tb.sv ====
`timescale 1ns/1ps

module mips_pipeline_tb;
    import mips_pkg::*;

    localparam int IM_DEPTH = 64;
    localparam int DM_DEPTH = 32;
    localparam int IM_AW    = $clog2(IM_DEPTH);
    localparam int DM_AW    = $clog2(DM_DEPTH);
    localparam int N_TESTS  = 5;
    localparam int MAX_PROG = 16;
    localparam int MAX_CHK  = 10;

    logic              i_clock;
    logic              i_reset;
    logic              i_run;
    logic              i_im_write;
    logic [IM_AW-1:0]  i_im_addr;
    logic [XLEN-1:0]   i_im_data;
    logic [REG_AW-1:0] i_rb_addr;
    logic [DM_AW-1:0]  i_dm_addr;
    logic              o_hlt;
    logic [XLEN-1:0]   o_rb_data;
    logic [XLEN-1:0]   o_dm_data;

    string       test_name [N_TESTS];
    logic [31:0] prog      [N_TESTS][MAX_PROG];
    int          prog_len  [N_TESTS];
    int          n_chk     [N_TESTS];
    bit          chk_mem   [N_TESTS][MAX_CHK];   // 0 register, 1 data word
    int          chk_addr  [N_TESTS][MAX_CHK];
    logic [31:0] chk_exp   [N_TESTS][MAX_CHK];

    int errors;
    int run_cycles;
    int cycle_limit;

    mips_pipeline #(.IM_DEPTH(IM_DEPTH), .DM_DEPTH(DM_DEPTH)) i_mips_pipeline (
        .i_clock(i_clock), .i_reset(i_reset), .i_run(i_run),
        .i_im_write(i_im_write), .i_im_addr(i_im_addr), .i_im_data(i_im_data),
        .i_rb_addr(i_rb_addr), .i_dm_addr(i_dm_addr),
        .o_hlt(o_hlt), .o_rb_data(o_rb_data), .o_dm_data(o_dm_data)
    );

    initial begin
        i_clock = 1'b0;
        forever #50 i_clock = ~i_clock;
    end

    // Watchdog over the cycles spent running programs
    always @(posedge i_clock) begin
        if (i_run) begin
            run_cycles = run_cycles + 1;
            if (run_cycles > cycle_limit) begin
                $display("Timeout: programs did not halt within %0d run cycles", cycle_limit);
                $display("Finished with errors");
                $finish;
            end
        end
    end

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] enc_r(input logic [5:0] funct, input int rd, rs, rt);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input int rt, rs,
                                          input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic add_instr(input int t, input logic [31:0] w);
        prog[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    task automatic expect_val(input int t, input bit is_mem, input int addr,
                              input logic [31:0] v);
        chk_mem[t][n_chk[t]]  = is_mem;
        chk_addr[t][n_chk[t]] = addr;
        chk_exp[t][n_chk[t]]  = v;
        n_chk[t]++;
    endtask

    task automatic build_tests();
        logic [15:0] ia;
        logic [15:0] ib;
        logic [15:0] ic;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] r3;
        logic [31:0] r4;
        logic [31:0] r5;
        ia = 16'($urandom());
        ib = 16'($urandom());
        a  = sext16(ia);
        b  = sext16(ib);
        r3 = a + b;
        r4 = r3 - a;
        r5 = r3 & r4;
        test_name[0] = "rtype_chain";
        add_instr(0, enc_i(OP_ADDI, 1, 0, ia));
        add_instr(0, enc_i(OP_ADDI, 2, 0, ib));
        add_instr(0, enc_r(FN_ADDU, 3, 1, 2));
        add_instr(0, enc_r(FN_SUBU, 4, 3, 1));
        add_instr(0, enc_r(FN_AND, 5, 3, 4));
        add_instr(0, enc_r(FN_OR, 6, 5, 1));
        add_instr(0, enc_r(FN_ADDU, 7, 6, 6));
        add_instr(0, {OP_HALT, 26'd0});
        expect_val(0, 0, 3, r3);
        expect_val(0, 0, 4, r4);
        expect_val(0, 0, 5, r5);
        expect_val(0, 0, 6, r5 | a);
        expect_val(0, 0, 7, (r5 | a) + (r5 | a));

        ia = 16'($urandom()) | 16'h8000;  // Negative
        ib = 16'($urandom()) & 16'h7fff;
        ic = 16'($urandom());
        a  = sext16(ia);
        b  = sext16(ib);
        c  = a + sext16(ic);
        test_name[1] = "addi_slt";
        add_instr(1, enc_i(OP_ADDI, 1, 0, ia));
        add_instr(1, enc_i(OP_ADDI, 2, 0, ib));
        add_instr(1, enc_i(OP_ADDI, 3, 1, ic));
        add_instr(1, enc_r(FN_SLT, 4, 1, 2));
        add_instr(1, enc_r(FN_SLT, 5, 2, 1));
        add_instr(1, enc_r(FN_SLT, 6, 3, 2));
        add_instr(1, {OP_HALT, 26'd0});
        expect_val(1, 0, 1, a);
        expect_val(1, 0, 2, b);
        expect_val(1, 0, 3, c);
        expect_val(1, 0, 4, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        expect_val(1, 0, 5, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        expect_val(1, 0, 6, ($signed(c) < $signed(b)) ? 32'd1 : 32'd0);

        ia = 16'($urandom());
        a  = sext16(ia);
        test_name[2] = "load_store";
        add_instr(2, enc_i(OP_ADDI, 1, 0, ia));
        add_instr(2, enc_i(OP_ADDI, 2, 0, 16'd8));
        add_instr(2, enc_i(OP_SW, 1, 2, 16'd4));   // Word 3
        add_instr(2, enc_i(OP_LW, 3, 2, 16'd4));
        add_instr(2, enc_r(FN_ADDU, 4, 3, 3));      // Load-use
        add_instr(2, enc_i(OP_SW, 4, 2, 16'd0));   // Word 2
        add_instr(2, enc_i(OP_LW, 5, 2, 16'd0));
        add_instr(2, enc_r(FN_OR, 6, 5, 1));
        add_instr(2, {OP_HALT, 26'd0});
        expect_val(2, 0, 3, a);
        expect_val(2, 0, 4, a + a);
        expect_val(2, 0, 5, a + a);
        expect_val(2, 0, 6, (a + a) | a);
        expect_val(2, 1, 3, a);
        expect_val(2, 1, 2, a + a);

        ia = 16'($urandom()) | 16'h0001;
        test_name[3] = "branch";
        add_instr(3, enc_i(OP_ADDI, 1, 0, ia));
        add_instr(3, enc_i(OP_ADDI, 2, 0, ia));
        add_instr(3, enc_i(OP_BEQ, 2, 1, 16'd3));   // Taken
        add_instr(3, enc_i(OP_ADDI, 3, 0, 16'd1));
        add_instr(3, enc_i(OP_ADDI, 4, 0, 16'd2));
        add_instr(3, enc_i(OP_ADDI, 5, 0, 16'd3));
        add_instr(3, enc_i(OP_BEQ, 0, 1, 16'd1));   // Not taken
        add_instr(3, enc_i(OP_ADDI, 6, 0, 16'd7));
        add_instr(3, enc_i(OP_ADDI, 7, 0, 16'd9));
        add_instr(3, {OP_HALT, 26'd0});
        expect_val(3, 0, 3, 32'd0);
        expect_val(3, 0, 4, 32'd0);
        expect_val(3, 0, 5, 32'd0);
        expect_val(3, 0, 6, 32'd7);
        expect_val(3, 0, 7, 32'd9);

        ia = 16'($urandom()) | 16'h0001;
        ib = 16'($urandom()) | 16'h0001;  // Nonzero so an r0 write shows
        a  = sext16(ia);
        test_name[4] = "halt_stop";
        add_instr(4, enc_i(OP_ADDI, 1, 0, ia));
        add_instr(4, enc_i(OP_ADDI, 0, 0, ib));
        add_instr(4, enc_i(OP_SW, 1, 0, 16'd20));
        add_instr(4, enc_i(OP_SW, 0, 0, 16'd24));
        add_instr(4, {OP_HALT, 26'd0});
        add_instr(4, enc_i(OP_ADDI, 2, 0, 16'd1));
        add_instr(4, enc_i(OP_SW, 1, 0, 16'd24));
        add_instr(4, enc_i(OP_ADDI, 3, 0, 16'd2));
        add_instr(4, {OP_HALT, 26'd0});
        expect_val(4, 0, 0, 32'd0);
        expect_val(4, 0, 1, a);
        expect_val(4, 0, 2, 32'd0);
        expect_val(4, 0, 3, 32'd0);
        expect_val(4, 1, 5, a);
        expect_val(4, 1, 6, 32'd0);
    endtask

    task automatic apply_reset();
        @(posedge i_clock);
        #5;
        i_reset = 1'b1;
        repeat (3) @(posedge i_clock);
        #5;
        i_reset = 1'b0;
    endtask

    task automatic load_program(input int t);
        for (int i = 0; i < prog_len[t]; i++) begin
            @(posedge i_clock);
            #5;
            i_im_write = 1'b1;
            i_im_addr  = IM_AW'(i);
            i_im_data  = prog[t][i];
        end
        @(posedge i_clock);
        #5;
        i_im_write = 1'b0;
    endtask

    // Debug ports answer one cycle after the address
    task automatic read_debug(input bit is_mem, input int addr, output logic [31:0] v);
        @(posedge i_clock);
        #5;
        if (is_mem) begin
            i_dm_addr = DM_AW'(addr);
        end else begin
            i_rb_addr = REG_AW'(addr);
        end
        @(posedge i_clock);
        @(negedge i_clock);
        v = is_mem ? o_dm_data : o_rb_data;
    endtask

    task automatic run_test(input int t);
        int          test_errs;
        logic [31:0] act;
        string       label;
        test_errs = 0;
        apply_reset();
        load_program(t);
        @(posedge i_clock);
        #5;
        i_run = 1'b1;
        do @(negedge i_clock); while (o_hlt !== 1'b1);
        @(posedge i_clock);
        #5;
        i_run = 1'b0;
        for (int k = 0; k < n_chk[t]; k++) begin
            read_debug(chk_mem[t][k], chk_addr[t][k], act);
            label = chk_mem[t][k] ? $sformatf("mem[%0d]", chk_addr[t][k])
                                  : $sformatf("r%0d", chk_addr[t][k]);
            assert (act === chk_exp[t][k]) else begin
                $display("Mismatch in %s: %s expected %h, actual %h",
                         test_name[t], label, chk_exp[t][k], act);
                test_errs++;
            end
        end
        assert (o_hlt === 1'b1) else begin
            $display("In %s the halt output dropped before the next reset", test_name[t]);
            test_errs++;
        end
        errors += test_errs;
        $display("%-12s %s (%0d checks, %0d errors)", test_name[t],
                 (test_errs == 0) ? "ok" : "failed", n_chk[t] + 1, test_errs);
    endtask

    initial begin
        i_reset    = 1'b1;
        i_run      = 1'b0;
        i_im_write = 1'b0;
        i_im_addr  = '0;
        i_im_data  = '0;
        i_rb_addr  = '0;
        i_dm_addr  = '0;
        errors     = 0;
        run_cycles = 0;
        void'($urandom(2572));
        build_tests();
        cycle_limit = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            cycle_limit += prog_len[t] * 4 + 20;
        end
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests run: %0d, errors: %0d", N_TESTS, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== mips_pipe.f ====
hdl/mips_pkg.sv
hdl/pipe_ifs.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/mips_pipeline.sv
dv/mips_pipeline_sva.sv
dv/mips_pipeline_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the pipeline testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f mips_pipe.f --top-module mips_pipeline_tb -o sim_mips
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_mips > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    exit 0
fi
exit 1
